/* wb_pkg.sv */
// ------------------------------------------------------------------------
// Wishbone classic bus widths and the vector types used on every port
// of the memory fabric. Referenced by scoped name, never imported.
// ------------------------------------------------------------------------

package wb_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // One select bit per byte lane
  localparam int unsigned SelWidth = DataWidth / 8;

  // Address bits below the word boundary
  localparam int unsigned ByteOffset = $clog2(SelWidth);

  typedef logic [AddrWidth-1:0] adr_t;
  typedef logic [DataWidth-1:0] dat_t;
  typedef logic [SelWidth-1:0]  sel_t;

endpackage

/* soc_pkg.sv */
// ------------------------------------------------------------------------
// SoC address map, region encoding, memory sizes, interruptor register
// offsets and the post-reset debug window. Shared by the RTL and the
// testbench through scoped names.
// ------------------------------------------------------------------------

package soc_pkg;

  // Address map
  localparam wb_pkg::adr_t RomBase     = 32'h0000_1000;
  localparam int unsigned  RomWords    = 16;
  localparam wb_pkg::adr_t RomLength   = wb_pkg::adr_t'(RomWords * wb_pkg::SelWidth);
  localparam int unsigned  RomIdxWidth = $clog2(RomWords);

  localparam wb_pkg::adr_t SramBase     = 32'h8000_0000;
  localparam int unsigned  SramWords    = 256;
  localparam wb_pkg::adr_t SramLength   = wb_pkg::adr_t'(SramWords * wb_pkg::SelWidth);
  localparam int unsigned  SramIdxWidth = $clog2(SramWords);

  localparam wb_pkg::adr_t ClintBase   = 32'h0200_0000;
  localparam wb_pkg::adr_t ClintLength = 32'h0001_0000;

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_ROM,
    REGION_SRAM,
    REGION_CLINT
  } region_e;

  // Interruptor offsets from ClintBase
  localparam wb_pkg::adr_t MsipOffset       = 32'h0000;
  localparam wb_pkg::adr_t MtimecmpLoOffset = 32'h4000;
  localparam wb_pkg::adr_t MtimecmpHiOffset = 32'h4004;
  localparam wb_pkg::adr_t MtimeLoOffset    = 32'hBFF8;
  localparam wb_pkg::adr_t MtimeHiOffset    = 32'hBFFC;

  // Upper half of every boot word
  localparam logic [15:0] RomTag = 16'hB007;

  localparam int unsigned DebugDelayCycles = 500;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  typedef logic [63:0] mtime_t;

endpackage

/* wb_decoder.sv */
// ------------------------------------------------------------------------
// Address decoder for the external Wishbone bus. Steers each cycle to
// the boot ROM, the SRAM or the interruptor, returns the selected
// slave's response and answers unmapped addresses with err itself.
// ------------------------------------------------------------------------

`timescale 1ns/100ps

module wb_decoder (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         cyc_i,
  input  logic         stb_i,
  input  wb_pkg::adr_t adr_i,
  output logic         rom_stb_o,
  output logic         sram_stb_o,
  output logic         clint_stb_o,
  input  wb_pkg::dat_t rom_dat_i,
  input  wb_pkg::dat_t sram_dat_i,
  input  wb_pkg::dat_t clint_dat_i,
  input  logic         rom_ack_i,
  input  logic         rom_err_i,
  input  logic         sram_ack_i,
  input  logic         clint_ack_i,
  output wb_pkg::dat_t dat_o,
  output logic         ack_o,
  output logic         err_o
);

  soc_pkg::region_e region;
  wb_pkg::adr_t     rom_off;
  wb_pkg::adr_t     sram_off;
  wb_pkg::adr_t     clint_off;
  logic             req;
  logic             none_stb;
  logic             err_q;
  logic             hold_q;

  assign req = cyc_i & stb_i;

  // Offsets wrap below the base, so one compare per region suffices
  assign rom_off   = adr_i - soc_pkg::RomBase;
  assign sram_off  = adr_i - soc_pkg::SramBase;
  assign clint_off = adr_i - soc_pkg::ClintBase;

  always_comb begin
    if (rom_off < soc_pkg::RomLength) begin
      region = soc_pkg::REGION_ROM;
    end else if (sram_off < soc_pkg::SramLength) begin
      region = soc_pkg::REGION_SRAM;
    end else if (clint_off < soc_pkg::ClintLength) begin
      region = soc_pkg::REGION_CLINT;
    end else begin
      region = soc_pkg::REGION_NONE;
    end
  end

  assign rom_stb_o   = req & (region == soc_pkg::REGION_ROM);
  assign sram_stb_o  = req & (region == soc_pkg::REGION_SRAM);
  assign clint_stb_o = req & (region == soc_pkg::REGION_CLINT);
  assign none_stb    = req & (region == soc_pkg::REGION_NONE);

  // ------------------------------------------------------------------------
  // Local err for unmapped cycles, one pulse per strobe
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_err
    if (!rst_ni) begin
      err_q  <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      err_q  <= none_stb & ~err_q & ~hold_q;
      hold_q <= none_stb & (err_q | hold_q);
    end
  end

  always_comb begin : p_resp_mux
    dat_o = '0;
    ack_o = 1'b0;
    err_o = 1'b0;
    case (region)
      soc_pkg::REGION_ROM: begin
        dat_o = rom_dat_i;
        ack_o = rom_ack_i;
        err_o = rom_err_i;
      end
      soc_pkg::REGION_SRAM: begin
        dat_o = sram_dat_i;
        ack_o = sram_ack_i;
      end
      soc_pkg::REGION_CLINT: begin
        dat_o = clint_dat_i;
        ack_o = clint_ack_i;
      end
      default: err_o = err_q;
    endcase
  end

  // Only one source answers in any cycle
  a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rom_ack_i | rom_err_i, sram_ack_i, clint_ack_i, err_q}));

endmodule

/* boot_rom.sv */
// ------------------------------------------------------------------------
// Read-only boot memory on the Wishbone bus. Each word carries the boot
// tag over its own index; writes are refused with err.
// ------------------------------------------------------------------------

`timescale 1ns/100ps

module boot_rom (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         stb_i,
  input  logic         we_i,
  input  wb_pkg::adr_t adr_i,
  output wb_pkg::dat_t dat_o,
  output logic         ack_o,
  output logic         err_o
);

  logic [soc_pkg::RomIdxWidth-1:0] idx;
  logic                            fire;
  logic                            ack_q;
  logic                            err_q;
  logic                            hold_q;
  wb_pkg::dat_t                    rdata_q;

  assign idx  = adr_i[wb_pkg::ByteOffset +: soc_pkg::RomIdxWidth];
  assign fire = stb_i & ~ack_q & ~err_q & ~hold_q;

  // Answer once per strobe, re-arm after stb drops
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_resp
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      ack_q  <= fire & ~we_i;
      err_q  <= fire & we_i;
      hold_q <= stb_i & (hold_q | ack_q | err_q);
    end
  end

  always_ff @(posedge clk_i) begin : p_rdata
    if (fire && !we_i) begin
      rdata_q <= {soc_pkg::RomTag, 16'(idx)};
    end
  end

  assign dat_o = rdata_q;
  assign ack_o = ack_q;
  assign err_o = err_q;

endmodule

/* sram_wb.sv */
// ------------------------------------------------------------------------
// Word-wide SRAM on the Wishbone bus. Writes merge only the selected byte
// lanes; reads return the full word together with ack.
// ------------------------------------------------------------------------

`timescale 1ns/100ps

module sram_wb (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         stb_i,
  input  logic         we_i,
  input  wb_pkg::adr_t adr_i,
  input  wb_pkg::dat_t dat_i,
  input  wb_pkg::sel_t sel_i,
  output wb_pkg::dat_t dat_o,
  output logic         ack_o
);

  wb_pkg::dat_t                     mem_q [soc_pkg::SramWords];
  logic [soc_pkg::SramIdxWidth-1:0] idx;
  logic                             fire;
  logic                             ack_q;
  logic                             hold_q;
  wb_pkg::dat_t                     rdata_q;

  assign idx  = adr_i[wb_pkg::ByteOffset +: soc_pkg::SramIdxWidth];
  assign fire = stb_i & ~ack_q & ~hold_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_resp
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      ack_q  <= fire;
      hold_q <= stb_i & (hold_q | ack_q);
    end
  end

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin : p_mem
    if (fire) begin
      if (we_i) begin
        for (int unsigned b = 0; b < wb_pkg::SelWidth; b++) begin
          if (sel_i[b]) begin
            mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign dat_o = rdata_q;
  assign ack_o = ack_q;

  // Every new strobe is answered in the next cycle
  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(stb_i) |=> ack_o);

endmodule

/* clint_regs.sv */
// ------------------------------------------------------------------------
// Bus side of the core-local interruptor: msip and the 64-bit compare
// value, plus readback of the time counter kept in the timer block.
// ------------------------------------------------------------------------

`timescale 1ns/100ps

module clint_regs (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            stb_i,
  input  logic            we_i,
  input  wb_pkg::adr_t    adr_i,
  input  wb_pkg::dat_t    dat_i,
  output wb_pkg::dat_t    dat_o,
  output logic            ack_o,
  output logic            ipi_o,
  output soc_pkg::mtime_t mtimecmp_o,
  input  soc_pkg::mtime_t mtime_i
);

  wb_pkg::adr_t    offset;
  logic            fire;
  logic            ack_q;
  logic            hold_q;
  logic            msip_q;
  soc_pkg::mtime_t mtimecmp_q;
  wb_pkg::dat_t    rdata_d;
  wb_pkg::dat_t    rdata_q;

  assign offset = adr_i - soc_pkg::ClintBase;
  assign fire   = stb_i & ~ack_q & ~hold_q;

  // Writes to mtime and unknown offsets fall through and are only acked
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      hold_q     <= 1'b0;
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
    end else begin
      ack_q  <= fire;
      hold_q <= stb_i & (hold_q | ack_q);
      if (fire && we_i) begin
        case (offset)
          soc_pkg::MsipOffset:       msip_q            <= dat_i[0];
          soc_pkg::MtimecmpLoOffset: mtimecmp_q[31:0]  <= dat_i;
          soc_pkg::MtimecmpHiOffset: mtimecmp_q[63:32] <= dat_i;
          default: ;
        endcase
      end
    end
  end

  always_comb begin : p_rdata_mux
    case (offset)
      soc_pkg::MsipOffset:       rdata_d = wb_pkg::dat_t'(msip_q);
      soc_pkg::MtimecmpLoOffset: rdata_d = mtimecmp_q[31:0];
      soc_pkg::MtimecmpHiOffset: rdata_d = mtimecmp_q[63:32];
      soc_pkg::MtimeLoOffset:    rdata_d = mtime_i[31:0];
      soc_pkg::MtimeHiOffset:    rdata_d = mtime_i[63:32];
      default:                   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin : p_rdata
    if (fire && !we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign dat_o      = rdata_q;
  assign ack_o      = ack_q;
  assign ipi_o      = msip_q;
  assign mtimecmp_o = mtimecmp_q;

endmodule

/* clint_timer.sv */
// ------------------------------------------------------------------------
// Time base of the interruptor. Counts synchronized rtc rising edges and
// raises the timer interrupt while mtime has reached the compare value.
// ------------------------------------------------------------------------

`timescale 1ns/100ps

module clint_timer (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            rtc_i,
  input  soc_pkg::mtime_t mtimecmp_i,
  output soc_pkg::mtime_t mtime_o,
  output logic            timer_irq_o
);

  logic [1:0]      rtc_sync_q;
  logic            rtc_prev_q;
  logic            rtc_rise;
  logic            timer_irq_q;
  soc_pkg::mtime_t mtime_q;

  // rtc is asynchronous to clk_i
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_timer
    if (!rst_ni) begin
      rtc_sync_q  <= '0;
      rtc_prev_q  <= 1'b0;
      mtime_q     <= '0;
      timer_irq_q <= 1'b0;
    end else begin
      rtc_sync_q  <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q  <= rtc_sync_q[1];
      timer_irq_q <= (mtime_q >= mtimecmp_i);
      if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  assign mtime_o     = mtime_q;
  assign timer_irq_o = timer_irq_q;

  // Time only moves forward, one tick at a time
  a_mtime_mono: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mtime_q == $past(mtime_q)) || (mtime_q == $past(mtime_q) + 64'd1));

endmodule

/* debug_gate.sv */
// ------------------------------------------------------------------------
// Holds back debug requests for a fixed window after reset, so boot code
// runs undisturbed before the first halt request can reach the core.
// ------------------------------------------------------------------------

`timescale 1ns/100ps

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [soc_pkg::DebugCntWidth-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_delay_cnt
    if (!rst_ni) begin
      cnt_q <= soc_pkg::DebugCntWidth'(soc_pkg::DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) & debug_req_i;

  // No request passes before the full window since reset release
  a_gate_closed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o |-> $past(rst_ni, soc_pkg::DebugDelayCycles));

endmodule

/* soc_fabric.sv */
// ------------------------------------------------------------------------
// Memory side of the simulation harness. An outside Wishbone master
// reaches the boot ROM, the SRAM and the interruptor through the decoder;
// debug requests pass the post-reset gate.
// ------------------------------------------------------------------------

`timescale 1ns/100ps

module soc_fabric (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         rtc_i,
  input  logic         wb_cyc_i,
  input  logic         wb_stb_i,
  input  logic         wb_we_i,
  input  wb_pkg::adr_t wb_adr_i,
  input  wb_pkg::dat_t wb_dat_i,
  input  wb_pkg::sel_t wb_sel_i,
  output wb_pkg::dat_t wb_dat_o,
  output logic         wb_ack_o,
  output logic         wb_err_o,
  input  logic         debug_req_i,
  output logic         debug_req_o,
  output logic         timer_irq_o,
  output logic         ipi_o
);

  logic            rom_stb;
  logic            sram_stb;
  logic            clint_stb;
  wb_pkg::dat_t    rom_dat;
  wb_pkg::dat_t    sram_dat;
  wb_pkg::dat_t    clint_dat;
  logic            rom_ack;
  logic            rom_err;
  logic            sram_ack;
  logic            clint_ack;
  soc_pkg::mtime_t mtimecmp;
  soc_pkg::mtime_t mtime;

  // ------------------------------------------------------------------------
  // Bus decode and slaves
  // ------------------------------------------------------------------------
  wb_decoder u_decoder (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .cyc_i       ( wb_cyc_i  ),
    .stb_i       ( wb_stb_i  ),
    .adr_i       ( wb_adr_i  ),
    .rom_stb_o   ( rom_stb   ),
    .sram_stb_o  ( sram_stb  ),
    .clint_stb_o ( clint_stb ),
    .rom_dat_i   ( rom_dat   ),
    .sram_dat_i  ( sram_dat  ),
    .clint_dat_i ( clint_dat ),
    .rom_ack_i   ( rom_ack   ),
    .rom_err_i   ( rom_err   ),
    .sram_ack_i  ( sram_ack  ),
    .clint_ack_i ( clint_ack ),
    .dat_o       ( wb_dat_o  ),
    .ack_o       ( wb_ack_o  ),
    .err_o       ( wb_err_o  )
  );

  boot_rom u_rom (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .stb_i  ( rom_stb  ),
    .we_i   ( wb_we_i  ),
    .adr_i  ( wb_adr_i ),
    .dat_o  ( rom_dat  ),
    .ack_o  ( rom_ack  ),
    .err_o  ( rom_err  )
  );

  sram_wb u_sram (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .stb_i  ( sram_stb ),
    .we_i   ( wb_we_i  ),
    .adr_i  ( wb_adr_i ),
    .dat_i  ( wb_dat_i ),
    .sel_i  ( wb_sel_i ),
    .dat_o  ( sram_dat ),
    .ack_o  ( sram_ack )
  );

  // ------------------------------------------------------------------------
  // Interruptor and debug gate
  // ------------------------------------------------------------------------
  clint_regs u_clint_regs (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .stb_i      ( clint_stb ),
    .we_i       ( wb_we_i   ),
    .adr_i      ( wb_adr_i  ),
    .dat_i      ( wb_dat_i  ),
    .dat_o      ( clint_dat ),
    .ack_o      ( clint_ack ),
    .ipi_o      ( ipi_o     ),
    .mtimecmp_o ( mtimecmp  ),
    .mtime_i    ( mtime     )
  );

  clint_timer u_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .mtimecmp_i  ( mtimecmp    ),
    .mtime_o     ( mtime       ),
    .timer_irq_o ( timer_irq_o )
  );

  debug_gate u_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

/* tb_soc_fabric.sv */
// ----------------------------------------------------------------------------
// Testbench for the memory fabric. Acts as the Wishbone master in place of
// the core, checks the debug gate, boot ROM, SRAM, unmapped decode and the
// interruptor, then prints one summary line and the final verdict.
// ----------------------------------------------------------------------------

`timescale 1ns/100ps

module tb_soc_fabric;

  localparam int unsigned BusTimeout = 20;
  localparam int unsigned IrqTimeout = 200;
  localparam int unsigned SramSlots  = 24;
  localparam int unsigned RandWrites = 64;

  logic            clk;
  logic            rst_n;
  logic            rtc;
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  wb_pkg::adr_t    wb_adr;
  wb_pkg::dat_t    wb_wdata;
  wb_pkg::sel_t    wb_sel;
  wb_pkg::dat_t    wb_rdata;
  logic            wb_ack;
  logic            wb_err;
  logic            debug_req;
  logic            debug_req_out;
  logic            timer_irq;
  logic            ipi;

  wb_pkg::dat_t    sram_shadow [soc_pkg::SramWords];
  string           chk_name_q [$];
  logic [63:0]     chk_exp_q [$];
  logic [63:0]     chk_act_q [$];
  int unsigned     checks;
  int unsigned     value_errors;
  int unsigned     other_errors;

  soc_fabric u_dut (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .rtc_i       ( rtc           ),
    .wb_cyc_i    ( wb_cyc        ),
    .wb_stb_i    ( wb_stb        ),
    .wb_we_i     ( wb_we         ),
    .wb_adr_i    ( wb_adr        ),
    .wb_dat_i    ( wb_wdata      ),
    .wb_sel_i    ( wb_sel        ),
    .wb_dat_o    ( wb_rdata      ),
    .wb_ack_o    ( wb_ack        ),
    .wb_err_o    ( wb_err        ),
    .debug_req_i ( debug_req     ),
    .debug_req_o ( debug_req_out ),
    .timer_irq_o ( timer_irq     ),
    .ipi_o       ( ipi           )
  );

  initial begin : p_clk
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // rtc runs 16 times slower than clk
  initial begin : p_rtc
    rtc <= 1'b0;
    forever begin
      repeat (8) @(posedge clk);
      rtc <= ~rtc;
    end
  end

  // ----------------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------------
  function automatic wb_pkg::dat_t merge_bytes(input wb_pkg::dat_t old_word,
                                               input wb_pkg::dat_t new_word,
                                               input wb_pkg::sel_t sel);
    wb_pkg::dat_t result;
    result = old_word;
    for (int b = 0; b < wb_pkg::SelWidth; b++) begin
      if (sel[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic wb_pkg::dat_t expected_read(input wb_pkg::adr_t adr);
    wb_pkg::adr_t off;
    off = adr - soc_pkg::RomBase;
    if (off < soc_pkg::RomWords * 4) begin
      return {soc_pkg::RomTag, 16'(off >> wb_pkg::ByteOffset)};
    end
    off = adr - soc_pkg::SramBase;
    if (off < soc_pkg::SramWords * 4) begin
      return sram_shadow[off >> wb_pkg::ByteOffset];
    end
    return '0;
  endfunction

  task automatic expect_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
    chk_name_q.push_back(name);
    chk_exp_q.push_back(exp_v);
    chk_act_q.push_back(act_v);
  endtask

  // Drains the pending checks once per clock
  always @(posedge clk) begin : p_compare
    string       name;
    logic [63:0] exp_v;
    logic [63:0] act_v;
    while (chk_act_q.size() != 0) begin
      name  = chk_name_q.pop_front();
      exp_v = chk_exp_q.pop_front();
      act_v = chk_act_q.pop_front();
      checks++;
      if (act_v !== exp_v) begin
        value_errors++;
        $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
      end
    end
  end

  task automatic abort_run(input string reason);
    other_errors++;
    $display("ERROR: %s", reason);
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    $display("TEST FAILED");
    $finish;
  endtask

  // ----------------------------------------------------------------------------
  // Bus master
  // ----------------------------------------------------------------------------
  task automatic wait_response(output wb_pkg::dat_t data, output logic [1:0] status,
                               output int unsigned lat);
    int unsigned cycles;
    cycles = 0;
    status = 2'b00;
    while (status == 2'b00) begin
      if (cycles >= BusTimeout) begin
        abort_run($sformatf("no ack or err for address %h", wb_adr));
      end
      @(posedge clk);
      cycles++;
      @(negedge clk);
      status = {wb_ack, wb_err};
      data   = wb_rdata;
    end
    lat = cycles;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_read(input wb_pkg::adr_t adr, output wb_pkg::dat_t data,
                          output logic [1:0] status, output int unsigned lat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_response(data, status, lat);
  endtask

  task automatic bus_write(input wb_pkg::adr_t adr, input wb_pkg::dat_t data,
                           input wb_pkg::sel_t sel, output logic [1:0] status);
    wb_pkg::dat_t unused;
    int unsigned  lat;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_wdata <= data;
    wb_sel   <= sel;
    wait_response(unused, status, lat);
  endtask

  task automatic read_mtime(output soc_pkg::mtime_t t);
    wb_pkg::dat_t lo;
    wb_pkg::dat_t hi;
    logic [1:0]   status;
    int unsigned  lat;
    bus_read(soc_pkg::ClintBase + soc_pkg::MtimeLoOffset, lo, status, lat);
    expect_value("mtime_lo_status", 2'b10, status);
    bus_read(soc_pkg::ClintBase + soc_pkg::MtimeHiOffset, hi, status, lat);
    expect_value("mtime_hi_status", 2'b10, status);
    t = {hi, lo};
  endtask

  task automatic wait_irq(input logic level);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (timer_irq !== level) begin
      if (cycles >= IrqTimeout) begin
        abort_run($sformatf("timer_irq_o did not reach %b in time", level));
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // ----------------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------------
  initial begin : p_main
    wb_pkg::adr_t    adr;
    wb_pkg::dat_t    rdata;
    wb_pkg::dat_t    wdata;
    wb_pkg::sel_t    sel;
    logic [1:0]      status;
    int unsigned     lat;
    int unsigned     slot;
    int unsigned     rnd;
    int unsigned     sram_idx [SramSlots];
    soc_pkg::mtime_t t_first;
    soc_pkg::mtime_t t_second;
    soc_pkg::mtime_t cmp;

    rnd          = $urandom(32'h894f_1121);
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    rst_n     <= 1'b0;
    wb_cyc    <= 1'b0;
    wb_stb    <= 1'b0;
    wb_we     <= 1'b0;
    wb_adr    <= '0;
    wb_wdata  <= '0;
    wb_sel    <= '0;
    debug_req <= 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Gate opens on the 500th edge after release
    repeat (soc_pkg::DebugDelayCycles - 1) @(posedge clk);
    @(negedge clk);
    expect_value("debug_gate_closed", 1'b0, debug_req_out);
    @(posedge clk);
    @(negedge clk);
    expect_value("debug_gate_open", 1'b1, debug_req_out);

    for (int i = 0; i < soc_pkg::RomWords; i++) begin
      adr = soc_pkg::RomBase + 4 * i;
      bus_read(adr, rdata, status, lat);
      expect_value($sformatf("rom_read_%0d", i), expected_read(adr), rdata);
      expect_value($sformatf("rom_read_status_%0d", i), 2'b10, status);
    end
    adr = soc_pkg::RomBase + 8;
    bus_write(adr, $urandom, 4'hF, status);
    expect_value("rom_write_status", 2'b01, status);
    bus_read(adr, rdata, status, lat);
    expect_value("rom_after_write", expected_read(adr), rdata);

    // SRAM slots start with full-word writes so every byte is known
    for (int s = 0; s < SramSlots; s++) begin
      sram_idx[s] = $urandom % soc_pkg::SramWords;
      wdata = $urandom;
      bus_write(soc_pkg::SramBase + 4 * sram_idx[s], wdata, 4'hF, status);
      sram_shadow[sram_idx[s]] = wdata;
      expect_value("sram_init_status", 2'b10, status);
    end
    for (int n = 0; n < RandWrites; n++) begin
      slot  = $urandom % SramSlots;
      wdata = $urandom;
      sel   = $urandom;
      bus_write(soc_pkg::SramBase + 4 * sram_idx[slot], wdata, sel, status);
      sram_shadow[sram_idx[slot]] = merge_bytes(sram_shadow[sram_idx[slot]], wdata, sel);
      expect_value("sram_write_status", 2'b10, status);
    end
    for (int s = 0; s < SramSlots; s++) begin
      adr = soc_pkg::SramBase + 4 * sram_idx[s];
      bus_read(adr, rdata, status, lat);
      expect_value($sformatf("sram_read_%0d", sram_idx[s]), expected_read(adr), rdata);
      expect_value("sram_read_status", 2'b10, status);
    end

    bus_read(32'h4000_0000, rdata, status, lat);
    expect_value("unmapped_read_status", 2'b01, status);
    expect_value("unmapped_read_latency", 1, lat);
    bus_read(soc_pkg::RomBase + soc_pkg::RomWords * 4, rdata, status, lat);
    expect_value("past_rom_status", 2'b01, status);
    bus_write(soc_pkg::ClintBase + soc_pkg::ClintLength, 32'h1, 4'hF, status);
    expect_value("past_clint_write_status", 2'b01, status);

    bus_write(soc_pkg::ClintBase + soc_pkg::MsipOffset, 32'h1, 4'hF, status);
    @(negedge clk);
    expect_value("ipi_set", 1'b1, ipi);
    bus_write(soc_pkg::ClintBase + soc_pkg::MsipOffset, 32'h0, 4'hF, status);
    @(negedge clk);
    expect_value("ipi_clear", 1'b0, ipi);

    read_mtime(t_first);
    repeat (40) @(posedge clk);
    read_mtime(t_second);
    if (t_second < t_first) begin
      other_errors++;
      $display("ERROR: mtime went backwards from %0d to %0d", t_first, t_second);
    end

    cmp = t_second + 3;
    bus_write(soc_pkg::ClintBase + soc_pkg::MtimecmpHiOffset, cmp[63:32], 4'hF, status);
    bus_write(soc_pkg::ClintBase + soc_pkg::MtimecmpLoOffset, cmp[31:0], 4'hF, status);
    @(negedge clk);
    expect_value("timer_irq_before_match", 1'b0, timer_irq);
    wait_irq(1'b1);
    bus_read(soc_pkg::ClintBase + soc_pkg::MtimecmpLoOffset, rdata, status, lat);
    expect_value("mtimecmp_lo_readback", cmp[31:0], rdata);
    bus_write(soc_pkg::ClintBase + soc_pkg::MtimecmpHiOffset, '1, 4'hF, status);
    bus_write(soc_pkg::ClintBase + soc_pkg::MtimecmpLoOffset, '1, 4'hF, status);
    wait_irq(1'b0);

    repeat (3) @(posedge clk);
    @(negedge clk);
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* soc_fabric.f */
wb_pkg.sv
soc_pkg.sv
wb_decoder.sv
boot_rom.sv
sram_wb.sv
clint_regs.sv
clint_timer.sv
debug_gate.sv
soc_fabric.sv
tb_soc_fabric.sv
